/* dnn_mem_rd_path.f */
logic/mem_bus_pkg.sv
logic/dnn_rd_pkg.sv
logic/sync_fifo.sv
logic/rd_sequencer.sv
logic/rd_response_path.sv
logic/dnn_mem_rd_path.sv
tests/mem_responder.sv
tests/tb_dnn_mem_rd_path.sv

/* run_sim.sh */
#!/bin/sh
# builds the read-path testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_dnn_mem_rd_path \
    -f dnn_mem_rd_path.f \
    --Mdir obj_dir -o tb_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test failures found" sim.log; then
    exit 1
fi
exit 0

/* tests/tb_dnn_mem_rd_path.sv */
// read-path testbench; needs timing support and assertions enabled, memory answers in request order
`timescale 1ns/1ps

module tb_dnn_mem_rd_path;

    import mem_bus_pkg::*;
    import dnn_rd_pkg::*;

    logic        clk;
    logic        rst;
    logic        rd_valid;
    rd_cmd_t     rd_cmd;
    logic        rd_ready;
    logic        mem_req_valid;
    mem_addr_t   mem_req_addr;
    logic        mem_req_ready;
    logic        mem_resp_valid;
    mem_data_t   mem_resp_data;
    logic        mem_resp_ready;
    logic        inbuf_full;
    logic        inbuf_push;
    inbuf_beat_t inbuf_beat;

    // test controls, picked up by their users on the rising edge
    logic mem_stall;
    logic full_toggle;

    // scoreboard, oldest first
    mem_addr_t   exp_req[$];
    inbuf_beat_t exp_beat[$];

    int errors;
    int tests_run;
    int tests_failed;
    int beats_sent;
    int req_seen;
    int push_seen;

    dnn_mem_rd_path i_dut (
        .clk            (clk),
        .rst            (rst),
        .rd_valid       (rd_valid),
        .rd_cmd         (rd_cmd),
        .rd_ready       (rd_ready),
        .mem_req_valid  (mem_req_valid),
        .mem_req_addr   (mem_req_addr),
        .mem_req_ready  (mem_req_ready),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_data  (mem_resp_data),
        .mem_resp_ready (mem_resp_ready),
        .inbuf_full     (inbuf_full),
        .inbuf_push     (inbuf_push),
        .inbuf_beat     (inbuf_beat)
    );

    mem_responder i_mem (
        .clk            (clk),
        .rst            (rst),
        .stall          (mem_stall),
        .mem_req_valid  (mem_req_valid),
        .mem_req_addr   (mem_req_addr),
        .mem_req_ready  (mem_req_ready),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_data  (mem_resp_data),
        .mem_resp_ready (mem_resp_ready)
    );

    // 4 ns clock
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // input buffer randomly full about one cycle in three when enabled
    initial begin : full_driver
        logic toggle;
        inbuf_full = 1'b0;
        forever begin
            @(posedge clk);
            toggle = full_toggle;
            @(negedge clk);
            inbuf_full = toggle && ($urandom_range(0, 2) == 0);
        end
    end

    // run limit grows with the beats the DUT has accepted
    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles <= 2000 + 200 * beats_sent) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles with %0d beats accepted", cycles, beats_sent);
        $display("Test failures found");
        $finish;
    end

    function automatic void check_value(input string name, input logic [63:0] want,
                                        input logic [63:0] got);
        a_value: assert (got === want)
            else begin
                $display("FAIL %s exp %h got %h", name, want, got);
                errors++;
            end
    endfunction

    // expected beats of one accepted command, 32-bit address steps then zero-extended
    function automatic void expect_cmd(input rd_cmd_t cmd);
        logic [31:0] a;
        inbuf_beat_t b;
        for (int i = 0; i < int'(cmd.beats); i++) begin
            a = cmd.address + 32'(8 * i);
            b.address = 64'(a);
            // model data: inverted low word on top
            b.data = {~a, a};
            b.last = (i == int'(cmd.beats) - 1);
            exp_req.push_back(b.address);
            exp_beat.push_back(b);
        end
        beats_sent += int'(cmd.beats);
    endfunction

    function automatic void take_req(input mem_addr_t addr);
        req_seen++;
        a_req_expected: assert (exp_req.size() != 0)
            else begin
                $display("memory request for %h with no beat outstanding", addr);
                errors++;
            end
        if (exp_req.size() != 0) begin
            check_value("mem_req_addr", exp_req.pop_front(), addr);
        end
    endfunction

    function automatic void take_beat(input inbuf_beat_t beat);
        inbuf_beat_t want;
        push_seen++;
        a_beat_expected: assert (exp_beat.size() != 0)
            else begin
                $display("input-buffer push at %h with no beat outstanding", beat.address);
                errors++;
            end
        if (exp_beat.size() != 0) begin
            want = exp_beat.pop_front();
            check_value("inbuf_beat.address", want.address, beat.address);
            check_value("inbuf_beat.data", want.data, beat.data);
            check_value("inbuf_beat.last", 64'(want.last), 64'(beat.last));
        end
    endfunction

    // transfers seen on the rising edge
    always @(posedge clk) begin
        if (!rst) begin
            if (rd_valid && rd_ready) begin
                expect_cmd(rd_cmd);
            end
            if (mem_req_valid && mem_req_ready) begin
                take_req(mem_req_addr);
            end
            if (inbuf_push) begin
                take_beat(inbuf_beat);
            end
        end
    end

    a_push_room: assert property (@(posedge clk) disable iff (rst) inbuf_push |-> !inbuf_full)
        else begin
            $display("inbuf_push was high while inbuf_full was high");
            errors++;
        end

    // stalled request keeps valid and address
    a_req_hold: assert property (@(posedge clk) disable iff (rst)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req_addr))
        else begin
            $display("memory request dropped or changed while mem_req_ready was low");
            errors++;
        end

    a_req_upper: assert property (@(posedge clk) disable iff (rst)
        mem_req_valid |-> mem_req_addr[63:32] == 32'h0)
        else begin
            $display("FAIL mem_req_addr[63:32] exp %h got %h", 32'h0, $sampled(mem_req_addr[63:32]));
            errors++;
        end

    // leaves rd_valid high after the transfer so commands can run back to back
    // rd_ready only moves on the rising edge, so it is read before the edge
    task automatic send_cmd(input logic [31:0] addr, input logic [9:0] beats);
        logic taken;
        @(negedge clk);
        rd_valid = 1'b1;
        rd_cmd   = '{address: addr, beats: beats};
        do begin
            taken = rd_ready;
            @(posedge clk);
            if (!taken) begin
                @(negedge clk);
            end
        end while (!taken);
    endtask

    task automatic end_cmds();
        @(negedge clk);
        rd_valid = 1'b0;
    endtask

    task automatic set_controls(input logic stall, input logic toggle);
        @(negedge clk);
        mem_stall   = stall;
        full_toggle = toggle;
    endtask

    task automatic wait_drain();
        while (exp_req.size() != 0 || exp_beat.size() != 0) begin
            @(negedge clk);
        end
        // quiet cycles so a stray request or push still shows up
        repeat (8) @(negedge clk);
    endtask

    task automatic expect_ready_drop(input int limit);
        int n;
        n = 0;
        while (rd_ready && n < limit) begin
            @(negedge clk);
            n++;
        end
        a_ready_drop: assert (!rd_ready)
            else begin
                $display("rd_ready stayed high for %0d cycles with memory stalled", n);
                errors++;
            end
    endtask

    function automatic void report_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, errors - errs_before);
        end
    endfunction

    initial begin : main
        int         errs;
        int         req_base;
        int         push_base;
        int         sum;
        logic [9:0] n;
        void'($urandom(32'h60fa_99bc));
        rst         = 1'b1;
        rd_valid    = 1'b0;
        rd_cmd      = '0;
        mem_stall   = 1'b0;
        full_toggle = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // idle outputs straight after reset
        errs = errors;
        check_value("mem_req_valid", 64'h0, 64'(mem_req_valid));
        check_value("inbuf_push", 64'h0, 64'(inbuf_push));
        check_value("rd_ready", 64'h1, 64'(rd_ready));
        check_value("mem_resp_ready", 64'h1, 64'(mem_resp_ready));
        report_test("reset_state", errs);

        errs = errors;
        send_cmd(32'h0000_1000, 10'd5);
        end_cmds();
        wait_drain();
        report_test("single_command", errs);

        // back-to-back commands, one of them empty, with a flickering input buffer
        errs      = errors;
        req_base  = req_seen;
        push_base = push_seen;
        sum       = 0;
        set_controls(1'b0, 1'b1);
        for (int k = 0; k < 12; k++) begin
            n = (k == 3) ? 10'd0 : 10'($urandom_range(1, 12));
            sum += int'(n);
            send_cmd($urandom(), n);
        end
        end_cmds();
        wait_drain();
        check_value("request count", 64'(sum), 64'(req_seen - req_base));
        check_value("inbuf_push count", 64'(sum), 64'(push_seen - push_base));
        set_controls(1'b0, 1'b0);
        report_test("random_commands", errs);

        // memory stalled until the command queue backs up
        errs = errors;
        set_controls(1'b1, 1'b0);
        fork
            begin
                for (int k = 0; k < 12; k++) begin
                    send_cmd(32'h8000_0000 + 32'(k * 64), 10'd4);
                end
                end_cmds();
            end
            begin
                expect_ready_drop(400);
                // the next command stays offered meanwhile
                repeat (20) @(negedge clk);
                check_value("rd_ready", 64'h0, 64'(rd_ready));
                set_controls(1'b0, 1'b0);
            end
        join
        wait_drain();
        report_test("request_backpressure", errs);

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* tests/mem_responder.sv */
// in-order memory model for the testbench; random ready and 1 to 6 cycle latency, data from address
`timescale 1ns/1ps

module mem_responder (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   stall,
    input  logic                   mem_req_valid,
    input  mem_bus_pkg::mem_addr_t mem_req_addr,
    output logic                   mem_req_ready,
    output logic                   mem_resp_valid,
    output mem_bus_pkg::mem_data_t mem_resp_data,
    input  logic                   mem_resp_ready
);

    import mem_bus_pkg::*;

    // accepted requests still owed a response, oldest first
    mem_addr_t pend_addr[$];
    // cycle from which each response may be presented
    int        pend_due[$];
    int        cycle;
    logic      stall_q;

    // bookkeeping on the rising edge, where the transfers happen
    always @(posedge clk) begin
        stall_q <= stall;
        cycle   <= cycle + 1;
        if (rst) begin
            pend_addr.delete();
            pend_due.delete();
        end else begin
            // head response leaves once the DUT takes it
            if (mem_resp_valid && mem_resp_ready) begin
                void'(pend_addr.pop_front());
                void'(pend_due.pop_front());
            end
            if (mem_req_valid && mem_req_ready) begin
                pend_addr.push_back(mem_req_addr);
                pend_due.push_back(cycle + int'($urandom_range(1, 6)));
            end
        end
    end

    // outputs change on the falling edge only
    initial begin
        mem_req_ready  = 1'b0;
        mem_resp_valid = 1'b0;
        mem_resp_data  = '0;
        forever begin
            @(negedge clk);
            // ready low about one cycle in four, always low while stalled
            mem_req_ready = !stall_q && ($urandom_range(0, 3) != 0);
            // head stays presented until accepted, so payload holds
            if (pend_addr.size() != 0 && pend_due[0] <= cycle) begin
                mem_resp_valid = 1'b1;
                mem_resp_data  = {~pend_addr[0][31:0], pend_addr[0][31:0]};
            end else begin
                mem_resp_valid = 1'b0;
            end
        end
    end

endmodule

/* logic/dnn_mem_rd_path.sv */
// read-only adapter top; payloads must hold while valid is high, one response per request in order
`timescale 1ns/1ps

module dnn_mem_rd_path (
    input  logic                    clk,
    input  logic                    rst,

    // read commands from the accelerator
    input  logic                    rd_valid,
    input  dnn_rd_pkg::rd_cmd_t     rd_cmd,
    output logic                    rd_ready,

    // memory request channel
    output logic                    mem_req_valid,
    output mem_bus_pkg::mem_addr_t  mem_req_addr,
    input  logic                    mem_req_ready,

    // memory response channel
    input  logic                    mem_resp_valid,
    input  mem_bus_pkg::mem_data_t  mem_resp_data,
    output logic                    mem_resp_ready,

    // accelerator input buffer
    input  logic                    inbuf_full,
    output logic                    inbuf_push,
    output dnn_rd_pkg::inbuf_beat_t inbuf_beat
);

    import mem_bus_pkg::*;
    import dnn_rd_pkg::*;

    // command queue
    rd_cmd_t cmd_head;
    logic    cmd_full;
    logic    cmd_empty;
    logic    cmd_push;
    logic    cmd_pop;

    // request queue
    mem_addr_t beat_addr;
    logic      req_full;
    logic      req_empty;
    logic      req_pop;

    // sequencer to both queues
    rd_tag_t beat_tag;
    logic    beat_push;
    logic    tag_full;

    // commands are taken whenever the queue has a free slot
    assign rd_ready = !cmd_full;
    assign cmd_push = rd_valid && rd_ready;

    sync_fifo #(
        .width ($bits(rd_cmd_t)),
        .depth (cmd_q_depth)
    ) i_cmd_q (
        .clk   (clk),
        .rst   (rst),
        .push  (cmd_push),
        .wdata (rd_cmd),
        .full  (cmd_full),
        .pop   (cmd_pop),
        .rdata (cmd_head),
        .empty (cmd_empty)
    );

    rd_sequencer i_seq (
        .clk       (clk),
        .rst       (rst),
        .cmd       (cmd_head),
        .cmd_empty (cmd_empty),
        .cmd_pop   (cmd_pop),
        .req_full  (req_full),
        .tag_full  (tag_full),
        .beat_push (beat_push),
        .beat_addr (beat_addr),
        .beat_tag  (beat_tag)
    );

    // head of the request queue drives the memory port directly
    sync_fifo #(
        .width ($bits(mem_addr_t)),
        .depth (req_q_depth)
    ) i_req_q (
        .clk   (clk),
        .rst   (rst),
        .push  (beat_push),
        .wdata (beat_addr),
        .full  (req_full),
        .pop   (req_pop),
        .rdata (mem_req_addr),
        .empty (req_empty)
    );

    assign mem_req_valid = !req_empty;
    assign req_pop       = mem_req_valid && mem_req_ready;

    // tag queue lives with the response side
    rd_response_path i_resp (
        .clk            (clk),
        .rst            (rst),
        .tag_push       (beat_push),
        .tag_in         (beat_tag),
        .tag_full       (tag_full),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_data  (mem_resp_data),
        .mem_resp_ready (mem_resp_ready),
        .inbuf_full     (inbuf_full),
        .inbuf_push     (inbuf_push),
        .inbuf_beat     (inbuf_beat)
    );

endmodule

/* logic/rd_response_path.sv */
// pairs in-order memory responses with issued tags; memory must return exactly one response per request
`timescale 1ns/1ps

module rd_response_path (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    tag_push,
    input  dnn_rd_pkg::rd_tag_t     tag_in,
    output logic                    tag_full,
    input  logic                    mem_resp_valid,
    input  mem_bus_pkg::mem_data_t  mem_resp_data,
    output logic                    mem_resp_ready,
    input  logic                    inbuf_full,
    output logic                    inbuf_push,
    output dnn_rd_pkg::inbuf_beat_t inbuf_beat
);

    import mem_bus_pkg::*;
    import dnn_rd_pkg::*;

    rd_tag_t   tag_head;
    logic      tag_empty;
    mem_data_t resp_head;
    logic      resp_empty;
    logic      resp_full;
    logic      resp_push;
    logic      merge;

    // tags of beats in flight, oldest at the head
    sync_fifo #(
        .width ($bits(rd_tag_t)),
        .depth (tag_q_depth)
    ) i_tag_q (
        .clk   (clk),
        .rst   (rst),
        .push  (tag_push),
        .wdata (tag_in),
        .full  (tag_full),
        .pop   (merge),
        .rdata (tag_head),
        .empty (tag_empty)
    );

    // accept responses while there is room
    assign mem_resp_ready = !resp_full;
    assign resp_push      = mem_resp_valid && mem_resp_ready;

    sync_fifo #(
        .width ($bits(mem_data_t)),
        .depth (resp_q_depth)
    ) i_resp_q (
        .clk   (clk),
        .rst   (rst),
        .push  (resp_push),
        .wdata (mem_resp_data),
        .full  (resp_full),
        .pop   (merge),
        .rdata (resp_head),
        .empty (resp_empty)
    );

    // responses come back in order, so heads always belong together
    // both queues pop on the same cycle as the push
    assign merge = !tag_empty && !resp_empty && !inbuf_full;

    assign inbuf_push = merge;
    assign inbuf_beat = '{
        address: tag_head.address,
        data:    resp_head,
        last:    tag_head.last
    };

endmodule

/* logic/rd_sequencer.sv */
// splits one command at a time into 8-byte beats; address wraps at 4 GiB, zero-beat commands are dropped
`timescale 1ns/1ps

module rd_sequencer (
    input  logic                   clk,
    input  logic                   rst,
    input  dnn_rd_pkg::rd_cmd_t    cmd,
    input  logic                   cmd_empty,
    output logic                   cmd_pop,
    input  logic                   req_full,
    input  logic                   tag_full,
    output logic                   beat_push,
    output mem_bus_pkg::mem_addr_t beat_addr,
    output dnn_rd_pkg::rd_tag_t    beat_tag
);

    import mem_bus_pkg::*;
    import dnn_rd_pkg::*;

    seq_state_t state;
    seq_state_t state_next;

    // active command, address of the next beat and beats still to issue
    logic [dnn_addr_w-1:0]   cur_addr;
    logic [dnn_addr_w-1:0]   cur_addr_next;
    logic [beat_count_w-1:0] beats_left;
    logic [beat_count_w-1:0] beats_left_next;

    logic last_beat;
    logic room;

    // final beat of the active command
    assign last_beat = (beats_left == beat_count_w'(1));

    // request and tag queues are pushed together, so both need space
    assign room = !req_full && !tag_full;

    always_comb begin
        state_next      = state;
        cur_addr_next   = cur_addr;
        beats_left_next = beats_left;
        cmd_pop         = 1'b0;
        beat_push       = 1'b0;

        case (state)
            seq_idle: begin
                if (!cmd_empty) begin
                    // take the head command
                    cmd_pop = 1'b1;
                    // empty command is consumed and nothing issued
                    if (cmd.beats != '0) begin
                        cur_addr_next   = cmd.address;
                        beats_left_next = cmd.beats;
                        state_next      = seq_issue;
                    end
                end
            end
            seq_issue: begin
                // one beat per cycle while downstream has room
                if (room) begin
                    beat_push       = 1'b1;
                    cur_addr_next   = cur_addr + dnn_addr_w'(beat_bytes);
                    beats_left_next = beats_left - 1'b1;
                    if (last_beat) begin
                        // back to idle, next command loads one cycle later
                        state_next = seq_idle;
                    end
                end
            end
            default: begin
                state_next = seq_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= seq_idle;
            beats_left <= '0;
        end else begin
            state      <= state_next;
            beats_left <= beats_left_next;
        end
    end

    // address register only meaningful in issue
    always_ff @(posedge clk) begin
        cur_addr <= cur_addr_next;
    end

    // zero-extend to the memory address width
    assign beat_addr = mem_addr_w'(cur_addr);

    // tag carries what the input buffer needs alongside the data
    assign beat_tag = '{address: beat_addr, last: last_beat};

endmodule

/* logic/sync_fifo.sv */
// show-ahead FIFO; depth must be a power of two >= 2, callers must not push when full or pop when empty
`timescale 1ns/1ps

module sync_fifo #(
    parameter int width = 8,
    parameter int depth = 4
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             push,
    input  logic [width-1:0] wdata,
    output logic             full,
    input  logic             pop,
    output logic [width-1:0] rdata,
    output logic             empty
);

    // pointer and occupancy widths follow the depth
    localparam int ptr_w = $clog2(depth);
    localparam int cnt_w = ptr_w + 1;

    // storage, no reset needed on the payload
    logic [width-1:0] mem [depth];

    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;

    // write side
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wdata;
        end
    end

    // pointers wrap naturally since depth is a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // occupancy holds when push and pop coincide
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // head word always visible
    assign rdata = mem[rd_ptr];

    assign empty = (count == '0);
    assign full  = (count == cnt_w'(depth));

endmodule

/* logic/dnn_rd_pkg.sv */
// accelerator side of the read path: 32-bit addresses, beat counts up to 1023, power-of-two depths
package dnn_rd_pkg;

    import mem_bus_pkg::*;

    // accelerator address width
    localparam int dnn_addr_w = 32;

    // read length in 8-byte beats
    // a count of zero is legal and issues nothing
    localparam int beat_count_w = 10;

    // queue depths, each a power of two of at least 2
    // command queue lets a few commands wait behind the active one
    localparam int cmd_q_depth = 4;
    // requests waiting for the memory port
    localparam int req_q_depth = 8;
    // bounds the number of beats in flight
    localparam int tag_q_depth = 16;
    // responses waiting for room in the input buffer
    localparam int resp_q_depth = 8;

    // read command from the accelerator, 42 bits
    typedef struct packed {
        logic [dnn_addr_w-1:0]   address;
        logic [beat_count_w-1:0] beats;
    } rd_cmd_t;

    // per-beat tag kept until the matching response returns, 65 bits
    typedef struct packed {
        mem_addr_t address;
        logic      last;
    } rd_tag_t;

    // one beat written into the accelerator input buffer, 129 bits
    typedef struct packed {
        mem_addr_t address;
        mem_data_t data;
        logic      last;
    } inbuf_beat_t;

    // sequencer states
    typedef enum logic [0:0] {
        seq_idle,
        seq_issue
    } seq_state_t;

endpackage

/* logic/mem_bus_pkg.sv */
// memory side of the read path: 64-bit byte addresses, one 8-byte beat per request, no write support
package mem_bus_pkg;

    // memory port widths
    // address is a full byte address, zero-extended from the accelerator side
    localparam int mem_addr_w = 64;

    // one response word per request
    localparam int mem_data_w = 64;

    // bytes covered by one beat
    // the sequencer steps the address by this amount
    localparam int beat_bytes = mem_data_w / 8;

    // request address as presented on mem_req_addr
    typedef logic [mem_addr_w-1:0] mem_addr_t;

    // response payload as returned on mem_resp_data
    // memory answers strictly in request order, so no id travels with it
    typedef logic [mem_data_w-1:0] mem_data_t;

endpackage
